/* source/alu_other_consts.svh */
`ifndef ALU_OTHER_CONSTS_SVH
`define ALU_OTHER_CONSTS_SVH

// vector register geometry
`define VLEN                128
`define VLENB               16
`define XLEN                32

// element widths
`define BYTE_WIDTH          8
`define HWORD_WIDTH         16
`define WORD_WIDTH          32

// uop field widths
`define ROB_DEPTH_WIDTH     3
`define UOP_INDEX_WIDTH     3
`define REGFILE_INDEX_WIDTH 5

// rob result slots granted after reset
`define RESULT_CREDITS      4
`define CREDIT_WIDTH        3

`endif

/* source/alu_other_pkg.sv */
`include "alu_other_consts.svh"
`default_nettype none

package alu_other_pkg;

  typedef enum logic [2:0] {
    OPIVV = 3'b000,
    OPMVV = 3'b010,
    OPIVI = 3'b011,
    OPIVX = 3'b100
  } funct3_e;

  typedef enum logic [5:0] {
    VMINU      = 6'b000100,
    VMIN       = 6'b000101,
    VMAXU      = 6'b000110,
    VMAX       = 6'b000111,
    VXUNARY0   = 6'b010010,
    VMERGE_VMV = 6'b010111
  } funct6_e;

  // vs1 field under VXUNARY0
  typedef enum logic [4:0] {
    VZEXT_VF4 = 5'b00100,
    VSEXT_VF4 = 5'b00101,
    VZEXT_VF2 = 5'b00110,
    VSEXT_VF2 = 5'b00111
  } xunary_e;

  typedef enum logic [1:0] {
    EEW8  = 2'b00,
    EEW16 = 2'b01,
    EEW32 = 2'b10
  } eew_e;

  typedef enum logic [2:0] {
    OP_NONE,
    OP_MIN,
    OP_MAX,
    OP_MERGE,
    OP_MOVE,
    OP_EXTEND
  } alu_op_e;

  typedef struct packed {
    logic [`ROB_DEPTH_WIDTH-1:0]     rob_entry;
    funct6_e                         funct6;
    funct3_e                         funct3;
    logic                            vm;
    logic [`REGFILE_INDEX_WIDTH-1:0] vs1;
    logic [`UOP_INDEX_WIDTH-1:0]     uop_index;
    logic [`VLEN-1:0]                v0_data;
    logic                            v0_valid;
    logic [`VLEN-1:0]                vs1_data;
    logic                            vs1_valid;
    logic [`VLEN-1:0]                vs2_data;
    logic                            vs2_valid;
    eew_e                            vs2_eew;
    logic [`XLEN-1:0]                rs1_data;
    logic                            rs1_valid;
  } alu_uop_t;

  typedef struct packed {
    alu_op_e op;
    logic    is_signed;
    logic    use_scalar;
    // vf4 rather than vf2
    logic    ext_quarter;
    eew_e    eew;
  } alu_ctrl_t;

  typedef struct packed {
    logic [`ROB_DEPTH_WIDTH-1:0] rob_entry;
    logic [`VLEN-1:0]            w_data;
    logic                        ignore_vma;
  } alu_result_t;

endpackage

`default_nettype wire

/* source/alu_other_ctrl.sv */
`include "alu_other_consts.svh"
`timescale 1ns/10ps
`default_nettype none

module alu_other_ctrl
  import alu_other_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      uop_valid,
  input  alu_uop_t  uop,
  input  logic      credit_return,
  output logic      uop_ready,
  output logic      issue,
  output alu_ctrl_t ctrl
);

  logic                     legal;
  logic                     src_valid;
  logic [`CREDIT_WIDTH-1:0] credits;

  always_comb begin
    ctrl = '0;
    ctrl.op = OP_NONE;
    ctrl.eew = uop.vs2_eew;
    ctrl.use_scalar = uop.funct3 inside {OPIVX, OPIVI};
    src_valid = ctrl.use_scalar ? uop.rs1_valid : uop.vs1_valid;
    legal = 1'b0;
    case (uop.funct6)
      VMINU, VMIN, VMAXU, VMAX: begin
        if (uop.funct3 inside {OPIVV, OPIVX}) begin
          ctrl.op = (uop.funct6 inside {VMINU, VMIN}) ? OP_MIN : OP_MAX;
          ctrl.is_signed = uop.funct6 inside {VMIN, VMAX};
          legal = uop.vs2_valid & src_valid;
        end
      end
      VMERGE_VMV: begin
        if (uop.funct3 inside {OPIVV, OPIVX, OPIVI}) begin
          // vm=1 is vmv.v, vm=0 is vmerge
          ctrl.op = uop.vm ? OP_MOVE : OP_MERGE;
          legal = src_valid & (uop.vm | (uop.vs2_valid & uop.v0_valid));
        end
      end
      VXUNARY0: begin
        if (uop.funct3 == OPMVV) begin
          ctrl.op = OP_EXTEND;
          ctrl.is_signed = xunary_e'(uop.vs1) inside {VSEXT_VF2, VSEXT_VF4};
          case (xunary_e'(uop.vs1))
            VZEXT_VF2, VSEXT_VF2: begin
              legal = uop.vs2_valid & ~uop.vs1_valid &
                      (uop.vs2_eew inside {EEW8, EEW16});
            end
            VZEXT_VF4, VSEXT_VF4: begin
              ctrl.ext_quarter = 1'b1;
              legal = uop.vs2_valid & ~uop.vs1_valid & (uop.vs2_eew == EEW8);
            end
            default: ctrl.op = OP_NONE;
          endcase
        end
      end
      default: ;
    endcase
  end

  assign uop_ready = (credits != '0);
  // illegal uops are taken but never reach the rob
  assign issue = uop_valid & uop_ready & legal;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credits <= `CREDIT_WIDTH'(`RESULT_CREDITS);
    end else begin
      case ({issue, credit_return})
        2'b10: credits <= credits - 1'b1;
        2'b01: credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/alu_operand_prep.sv */
`include "alu_other_consts.svh"
`timescale 1ns/10ps
`default_nettype none

module alu_operand_prep
  import alu_other_pkg::*;
(
  input  alu_uop_t           uop,
  input  alu_ctrl_t          ctrl,
  output logic [`VLEN-1:0]   src1,
  output logic [`VLEN-1:0]   src2,
  output logic [`VLENB-1:0]  mask_bits
);

  // scalar broadcast at the element width
  always_comb begin
    if (!ctrl.use_scalar) begin
      src1 = uop.vs1_data;
    end else begin
      case (ctrl.eew)
        EEW8:    src1 = {(`VLEN/`BYTE_WIDTH){uop.rs1_data[`BYTE_WIDTH-1:0]}};
        EEW16:   src1 = {(`VLEN/`HWORD_WIDTH){uop.rs1_data[`HWORD_WIDTH-1:0]}};
        default: src1 = {(`VLEN/`WORD_WIDTH){uop.rs1_data[`WORD_WIDTH-1:0]}};
      endcase
    end
  end

  // extensions read one chunk of vs2 per uop
  always_comb begin
    src2 = uop.vs2_data;
    if (ctrl.op == OP_EXTEND) begin
      if (ctrl.ext_quarter) begin
        src2 = {4{uop.vs2_data[uop.uop_index[1:0]*(`VLEN/4) +: `VLEN/4]}};
      end else begin
        src2 = {2{uop.vs2_data[uop.uop_index[0]*(`VLEN/2) +: `VLEN/2]}};
      end
    end
  end

  always_comb begin
    case (ctrl.eew)
      EEW8: begin
        mask_bits = uop.v0_data[uop.uop_index*`VLENB +: `VLENB];
      end
      EEW16: begin
        mask_bits = {{(`VLENB/2){1'b0}}, uop.v0_data[uop.uop_index*(`VLENB/2) +: `VLENB/2]};
      end
      default: begin
        mask_bits = {{(`VLENB*3/4){1'b0}}, uop.v0_data[uop.uop_index*(`VLENB/4) +: `VLENB/4]};
      end
    endcase
  end

endmodule

`default_nettype wire

/* source/alu_minmax.sv */
`include "alu_other_consts.svh"
`timescale 1ns/10ps
`default_nettype none

module alu_minmax
  import alu_other_pkg::*;
(
  input  alu_ctrl_t        ctrl,
  input  logic [`VLEN-1:0] src1,
  input  logic [`VLEN-1:0] src2,
  output logic [`VLEN-1:0] data
);

  logic [2:0][`VLEN-1:0] width_data;

  // lane sets for 8, 16 and 32 bit elements
  for (genvar w = 0; w < 3; w++) begin : g_width
    localparam int W = `BYTE_WIDTH << w;
    for (genvar j = 0; j < `VLEN / W; j++) begin : g_lane
      logic [W:0] a;
      logic [W:0] b;
      logic       a_lt_b;
      // extra top bit makes one signed compare serve both kinds
      assign a = {ctrl.is_signed & src2[j*W+W-1], src2[j*W +: W]};
      assign b = {ctrl.is_signed & src1[j*W+W-1], src1[j*W +: W]};
      assign a_lt_b = $signed(a) < $signed(b);
      assign width_data[w][j*W +: W] = ((ctrl.op == OP_MIN) == a_lt_b) ? a[W-1:0] : b[W-1:0];
    end
  end

  always_comb begin
    case (ctrl.eew)
      EEW8:    data = width_data[0];
      EEW16:   data = width_data[1];
      default: data = width_data[2];
    endcase
  end

endmodule

`default_nettype wire

/* source/alu_extend.sv */
`include "alu_other_consts.svh"
`timescale 1ns/10ps
`default_nettype none

module alu_extend
  import alu_other_pkg::*;
(
  input  alu_ctrl_t        ctrl,
  input  logic [`VLEN-1:0] src2,
  output logic [`VLEN-1:0] data
);

  logic [2:0][`VLEN-1:0] ext_data;

  // 8->16, 16->32, 8->32
  for (genvar k = 0; k < 3; k++) begin : g_kind
    localparam int S = (k == 1) ? `HWORD_WIDTH : `BYTE_WIDTH;
    localparam int D = (k == 2) ? 4 * S : 2 * S;
    for (genvar j = 0; j < `VLEN / D; j++) begin : g_elem
      assign ext_data[k][j*D +: D] = {{(D-S){ctrl.is_signed & src2[j*S+S-1]}}, src2[j*S +: S]};
    end
  end

  always_comb begin
    if (ctrl.ext_quarter) begin
      data = ext_data[2];
    end else if (ctrl.eew == EEW16) begin
      data = ext_data[1];
    end else begin
      data = ext_data[0];
    end
  end

endmodule

`default_nettype wire

/* source/alu_merge.sv */
`include "alu_other_consts.svh"
`timescale 1ns/10ps
`default_nettype none

module alu_merge
  import alu_other_pkg::*;
(
  input  eew_e              eew,
  input  logic [`VLEN-1:0]  src1,
  input  logic [`VLEN-1:0]  src2,
  input  logic [`VLENB-1:0] mask_bits,
  output logic [`VLEN-1:0]  data
);

  logic [2:0][`VLEN-1:0] width_data;

  for (genvar w = 0; w < 3; w++) begin : g_width
    localparam int W = `BYTE_WIDTH << w;
    for (genvar j = 0; j < `VLEN / W; j++) begin : g_elem
      assign width_data[w][j*W +: W] = mask_bits[j] ? src1[j*W +: W] : src2[j*W +: W];
    end
  end

  always_comb begin
    case (eew)
      EEW8:    data = width_data[0];
      EEW16:   data = width_data[1];
      default: data = width_data[2];
    endcase
  end

endmodule

`default_nettype wire

/* source/alu_result_stage.sv */
`include "alu_other_consts.svh"
`timescale 1ns/10ps
`default_nettype none

module alu_result_stage
  import alu_other_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        issue,
  input  alu_ctrl_t                   ctrl,
  input  logic [`ROB_DEPTH_WIDTH-1:0] rob_entry,
  input  logic [`VLEN-1:0]            minmax_data,
  input  logic [`VLEN-1:0]            extend_data,
  input  logic [`VLEN-1:0]            merge_data,
  input  logic [`VLEN-1:0]            move_data,
  output logic                        result_valid,
  output alu_result_t                 result
);

  logic [`VLEN-1:0] sel_data;

  always_comb begin
    case (ctrl.op)
      OP_MIN, OP_MAX: sel_data = minmax_data;
      OP_MERGE:       sel_data = merge_data;
      OP_MOVE:        sel_data = move_data;
      OP_EXTEND:      sel_data = extend_data;
      default:        sel_data = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= issue;
    end
  end

  // payload only loads on issue
  always_ff @(posedge clk) begin
    if (issue) begin
      result.rob_entry  <= rob_entry;
      result.w_data     <= sel_data;
      result.ignore_vma <= (ctrl.op == OP_MERGE);
    end
  end

endmodule

`default_nettype wire

/* source/alu_unit_other.sv */
`include "alu_other_consts.svh"
`timescale 1ns/10ps
`default_nettype none

module alu_unit_other
  import alu_other_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        uop_valid,
  input  alu_uop_t    uop,
  output logic        uop_ready,
  input  logic        credit_return,
  output logic        result_valid,
  output alu_result_t result
);

  logic              issue;
  alu_ctrl_t         ctrl;
  logic [`VLEN-1:0]  src1;
  logic [`VLEN-1:0]  src2;
  logic [`VLENB-1:0] mask_bits;
  logic [`VLEN-1:0]  minmax_data;
  logic [`VLEN-1:0]  extend_data;
  logic [`VLEN-1:0]  merge_data;

  alu_other_ctrl ctrl_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .uop_valid     (uop_valid),
    .uop           (uop),
    .credit_return (credit_return),
    .uop_ready     (uop_ready),
    .issue         (issue),
    .ctrl          (ctrl)
  );

  alu_operand_prep prep_i (
    .uop       (uop),
    .ctrl      (ctrl),
    .src1      (src1),
    .src2      (src2),
    .mask_bits (mask_bits)
  );

  alu_minmax minmax_i (
    .ctrl (ctrl),
    .src1 (src1),
    .src2 (src2),
    .data (minmax_data)
  );

  alu_extend extend_i (
    .ctrl (ctrl),
    .src2 (src2),
    .data (extend_data)
  );

  alu_merge merge_i (
    .eew       (ctrl.eew),
    .src1      (src1),
    .src2      (src2),
    .mask_bits (mask_bits),
    .data      (merge_data)
  );

  // vmv.v result is the prepared src1
  alu_result_stage result_stage_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .issue        (issue),
    .ctrl         (ctrl),
    .rob_entry    (uop.rob_entry),
    .minmax_data  (minmax_data),
    .extend_data  (extend_data),
    .merge_data   (merge_data),
    .move_data    (src1),
    .result_valid (result_valid),
    .result       (result)
  );

endmodule

`default_nettype wire

/* verif/alu_unit_other_tb.sv */
`include "alu_other_consts.svh"
`timescale 1ns/10ps
`default_nettype none

module alu_unit_other_tb
  import alu_other_pkg::*;
;

  logic        clk;
  logic        rst_n;
  logic        uop_valid;
  alu_uop_t    uop;
  logic        uop_ready;
  logic        credit_return;
  logic        result_valid;
  alu_result_t result;

  // stimulus table
  string       test_name [$];
  alu_uop_t    test_uop [$];
  logic        test_valid [$];
  alu_result_t test_exp [$];
  logic        table_ready = 1'b0;

  logic [31:0] lcg_state = 32'h1ed5_0fc1;
  logic [2:0]  rob_next = 3'd0;
  int          errors;
  int          n_tests;
  int          n_failed;

  // result collection and credit return
  alu_result_t rcv_q [$];
  int          received;
  int          issued;
  int          returned;
  int          owed;
  int          release_credits;
  logic        hold_credits = 1'b0;
  logic        next_credit = 1'b0;

  funct6_e minmax_ops [4] = '{VMINU, VMIN, VMAXU, VMAX};
  funct3_e minmax_srcs [2] = '{OPIVV, OPIVX};
  funct3_e merge_srcs [3] = '{OPIVV, OPIVX, OPIVI};
  funct3_e move_srcs [2] = '{OPIVX, OPIVI};
  eew_e    eews [3] = '{EEW8, EEW16, EEW32};
  xunary_e ext_codes [4] = '{VZEXT_VF2, VSEXT_VF2, VZEXT_VF4, VSEXT_VF4};

  alu_unit_other dut_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .uop_valid     (uop_valid),
    .uop           (uop),
    .uop_ready     (uop_ready),
    .credit_return (credit_return),
    .result_valid  (result_valid),
    .result        (result)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [`VLEN-1:0] rand_vec();
    return {next_rand(), next_rand(), next_rand(), next_rand()};
  endfunction

  function automatic alu_uop_t make_uop(funct6_e f6, funct3_e f3, logic vm,
                                        logic [4:0] vs1, logic [2:0] idx, eew_e eew);
    alu_uop_t u;
    u = '0;
    u.funct6 = f6;
    u.funct3 = f3;
    u.vm = vm;
    u.vs1 = vs1;
    u.uop_index = idx;
    u.vs2_eew = eew;
    u.v0_data = rand_vec();
    u.vs1_data = rand_vec();
    u.vs2_data = rand_vec();
    u.rs1_data = next_rand();
    // immediates arrive as sign-extended simm5
    if (f3 == OPIVI) begin
      u.rs1_data = {{27{u.rs1_data[4]}}, u.rs1_data[4:0]};
    end
    u.v0_valid = 1'b1;
    u.vs2_valid = 1'b1;
    u.vs1_valid = (f3 == OPIVV);
    u.rs1_valid = (f3 == OPIVX || f3 == OPIVI);
    return u;
  endfunction

  // element-wise reference for the three operation groups
  function automatic logic [`VLEN-1:0] model_data(alu_uop_t u);
    int               w;
    int               f;
    int               d;
    int               chunk;
    logic [`VLEN-1:0] res;
    logic [`VLEN-1:0] emask;
    logic [`VLEN-1:0] dmask;
    logic [`VLEN-1:0] a;
    logic [`VLEN-1:0] b;
    longint           sa;
    longint           sb;
    logic             sgn;
    logic             take_b;
    res = '0;
    w = `BYTE_WIDTH << u.vs2_eew;
    emask = (`VLEN'(1) << w) - `VLEN'(1);
    if (u.funct6 == VXUNARY0) begin
      f = (u.vs1 inside {VZEXT_VF4, VSEXT_VF4}) ? 4 : 2;
      sgn = u.vs1 inside {VSEXT_VF2, VSEXT_VF4};
      d = w * f;
      dmask = (`VLEN'(1) << d) - `VLEN'(1);
      chunk = u.uop_index % f;
      for (int i = 0; i < `VLEN / d; i++) begin
        a = (u.vs2_data >> (chunk * (`VLEN / f) + i * w)) & emask;
        if (sgn && a[w-1]) begin
          a = a | ~emask;
        end
        res |= (a & dmask) << (i * d);
      end
    end else begin
      sgn = (u.funct6 == VMIN || u.funct6 == VMAX);
      for (int i = 0; i < `VLEN / w; i++) begin
        a = (u.vs2_data >> (i * w)) & emask;
        if (u.funct3 == OPIVX || u.funct3 == OPIVI) begin
          b = `VLEN'(u.rs1_data) & emask;
        end else begin
          b = (u.vs1_data >> (i * w)) & emask;
        end
        if (u.funct6 == VMERGE_VMV) begin
          take_b = u.vm || u.v0_data[u.uop_index * (`VLEN / w) + i];
        end else begin
          sa = longint'(a[31:0]);
          sb = longint'(b[31:0]);
          if (sgn && a[w-1]) sa = sa - (longint'(1) << w);
          if (sgn && b[w-1]) sb = sb - (longint'(1) << w);
          if (u.funct6 == VMINU || u.funct6 == VMIN) begin
            take_b = sb < sa;
          end else begin
            take_b = sb > sa;
          end
        end
        res |= (take_b ? b : a) << (i * w);
      end
    end
    return res;
  endfunction

  function automatic alu_result_t expect_result(alu_uop_t u);
    alu_result_t r;
    r.rob_entry = u.rob_entry;
    r.w_data = model_data(u);
    r.ignore_vma = (u.funct6 == VMERGE_VMV) && !u.vm;
    return r;
  endfunction

  task automatic add_test(string name, alu_uop_t u, logic legal);
    u.rob_entry = rob_next;
    rob_next = rob_next + 3'd1;
    test_name.push_back(name);
    test_uop.push_back(u);
    test_valid.push_back(legal);
    test_exp.push_back(expect_result(u));
  endtask

  task automatic build_table();
    logic [31:0] r;
    alu_uop_t    u;
    logic        quarter;
    foreach (minmax_ops[a]) begin
      foreach (minmax_srcs[b]) begin
        foreach (eews[c]) begin
          add_test($sformatf("%s_%s_%s", minmax_ops[a].name(), minmax_srcs[b].name(),
                   eews[c].name()), make_uop(minmax_ops[a], minmax_srcs[b], 1'b1, 5'd0,
                   3'd0, eews[c]), 1'b1);
        end
      end
    end
    foreach (merge_srcs[b]) begin
      foreach (eews[c]) begin
        r = next_rand();
        add_test($sformatf("vmerge_%s_%s_idx%0d", merge_srcs[b].name(), eews[c].name(),
                 r[2:0]), make_uop(VMERGE_VMV, merge_srcs[b], 1'b0, 5'd0, r[2:0], eews[c]),
                 1'b1);
      end
    end
    foreach (move_srcs[b]) begin
      foreach (eews[c]) begin
        add_test($sformatf("vmv_%s_%s", move_srcs[b].name(), eews[c].name()),
                 make_uop(VMERGE_VMV, move_srcs[b], 1'b1, 5'd0, 3'd0, eews[c]), 1'b1);
      end
    end
    // every chunk of vs2 for each extension kind
    for (int x = 0; x < 4; x++) begin
      quarter = (x >= 2);
      for (int e = 0; e < (quarter ? 1 : 2); e++) begin
        for (int k = 0; k < (quarter ? 4 : 2); k++) begin
          add_test($sformatf("%s_%s_idx%0d", ext_codes[x].name(), eews[e].name(), k),
                   make_uop(VXUNARY0, OPMVV, 1'b1, ext_codes[x], 3'(k), eews[e]), 1'b1);
        end
      end
    end
    u = make_uop(VMIN, OPIVV, 1'b1, 5'd0, 3'd0, EEW8);
    u.vs2_valid = 1'b0;
    add_test("illegal_no_vs2", u, 1'b0);
    add_test("after_no_vs2", make_uop(VMAX, OPIVV, 1'b1, 5'd0, 3'd0, EEW32), 1'b1);
    add_test("illegal_vf4_eew16", make_uop(VXUNARY0, OPMVV, 1'b1, VSEXT_VF4, 3'd1, EEW16), 1'b0);
    add_test("after_vf4_eew16", make_uop(VXUNARY0, OPMVV, 1'b1, VSEXT_VF2, 3'd1, EEW16), 1'b1);
    add_test("illegal_funct6", make_uop(funct6_e'(6'b000000), OPIVV, 1'b1, 5'd0, 3'd0, EEW8),
             1'b0);
    add_test("after_funct6", make_uop(VMINU, OPIVX, 1'b1, 5'd0, 3'd0, EEW16), 1'b1);
  endtask

  task automatic check_result(string name, alu_result_t exp, alu_result_t act);
    if (act !== exp) begin
      errors++;
      $display("error %s expected rob %0d data %h vma %b actual rob %0d data %h vma %b", name,
               exp.rob_entry, exp.w_data, exp.ignore_vma, act.rob_entry, act.w_data,
               act.ignore_vma);
    end
  endtask

  task automatic check_valid(string name, logic exp, logic act);
    if (act !== exp) begin
      errors++;
      $display("error %s expected result_valid %b actual %b", name, exp, act);
    end
  endtask

  task automatic check_ready(string name, logic exp, logic act);
    if (act !== exp) begin
      errors++;
      $display("error %s expected uop_ready %b actual %b", name, exp, act);
    end
  endtask

  task automatic end_test(string name, int base);
    n_tests++;
    if (errors != base) begin
      n_failed++;
      $display("%-28s fail", name);
    end else begin
      $display("%-28s pass", name);
    end
  endtask

  task automatic run_test(int i);
    int base;
    base = errors;
    @(posedge clk);
    #1;
    uop = test_uop[i];
    uop_valid = 1'b1;
    @(negedge clk);
    while (!uop_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    uop_valid = 1'b0;
    if (test_valid[i]) issued++;
    // result valid for one cycle right after acceptance
    @(negedge clk);
    check_valid(test_name[i], test_valid[i], result_valid);
    if (test_valid[i]) check_result(test_name[i], test_exp[i], result);
    @(negedge clk);
    check_valid(test_name[i], 1'b0, result_valid);
    end_test(test_name[i], base);
  endtask

  task automatic credit_test();
    string       name;
    alu_uop_t    cu [5];
    alu_result_t ce [5];
    int          base;
    name = "credit_backpressure";
    base = errors;
    for (int k = 0; k < 5; k++) begin
      cu[k] = make_uop(VMAX, OPIVX, 1'b1, 5'd0, 3'd0, eews[k % 3]);
      cu[k].rob_entry = 3'(k);
      ce[k] = expect_result(cu[k]);
    end
    // start with the full credit count
    while (returned != issued) begin
      @(posedge clk);
    end
    @(posedge clk);
    #1;
    hold_credits = 1'b1;
    rcv_q.delete();
    for (int k = 0; k < 4; k++) begin
      uop = cu[k];
      uop_valid = 1'b1;
      @(posedge clk);
      #1;
    end
    uop_valid = 1'b0;
    @(negedge clk);
    check_ready(name, 1'b0, uop_ready);
    @(posedge clk);
    #1;
    uop = cu[4];
    uop_valid = 1'b1;
    repeat (3) @(negedge clk);
    check_ready(name, 1'b0, uop_ready);
    @(posedge clk);
    #1;
    release_credits = 1;
    for (int c = 0; c < 4 && !uop_ready; c++) begin
      @(negedge clk);
    end
    check_ready(name, 1'b1, uop_ready);
    @(posedge clk);
    #1;
    uop_valid = 1'b0;
    issued += 5;
    while (rcv_q.size() < 5) begin
      @(posedge clk);
    end
    for (int k = 0; k < 5; k++) begin
      check_result(name, ce[k], rcv_q[k]);
    end
    end_test(name, base);
  endtask

  always @(negedge clk) begin
    if (rst_n && result_valid) begin
      rcv_q.push_back(result);
      received++;
      if (!hold_credits) owed++;
    end
    owed += release_credits;
    release_credits = 0;
    next_credit = (owed > 0);
    if (next_credit) begin
      owed--;
      returned++;
    end
  end

  always @(posedge clk) begin
    #1;
    credit_return = next_credit;
  end

  initial begin
    wait (table_ready);
    repeat ((test_name.size() + 5) * 20 + 10) @(posedge clk);
    $display("timeout: the run did not finish in the expected time");
    $display("Errors found");
    $finish;
  end

  initial begin
    int base;
    rst_n = 1'b0;
    uop_valid = 1'b0;
    uop = '0;
    credit_return = 1'b0;
    build_table();
    table_ready = 1'b1;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    base = errors;
    @(negedge clk);
    check_ready("reset_state", 1'b1, uop_ready);
    check_valid("reset_state", 1'b0, result_valid);
    end_test("reset_state", base);
    foreach (test_name[i]) begin
      run_test(i);
    end
    credit_test();
    base = errors;
    if (received != issued) begin
      errors++;
      $display("error result_count expected %0d actual %0d", issued, received);
    end
    end_test("result_count", base);
    $display("%0d tests, %0d failed, %0d errors", n_tests, n_failed, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+source
source/alu_other_pkg.sv
source/alu_other_ctrl.sv
source/alu_operand_prep.sv
source/alu_minmax.sv
source/alu_extend.sv
source/alu_merge.sv
source/alu_result_stage.sv
source/alu_unit_other.sv
verif/alu_unit_other_tb.sv

/* Makefile */
.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing -j 0 -f all.f --top-module alu_unit_other_tb
	out="$$(./obj_dir/Valu_unit_other_tb)"; echo "$$out"; \
	echo "$$out" | grep -q "No errors"

lint:
	verilator --lint-only --timing -f all.f --top-module alu_unit_other
	verilator --lint-only --timing -f all.f --top-module alu_unit_other_tb

clean:
	rm -rf obj_dir
